// ==== include/dds_params.svh ====
`ifndef DDS_PARAMS_SVH
`define DDS_PARAMS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

`define PHASE_W      32   // phase accumulator
`define SAMPLE_W     12   // signed two's complement samples
`define PHASE_IDX_W  12   // top accumulator bits used as waveform index
`define TABLE_AW     6    // quarter-wave table, 64 entries

////////////////////////////////////////
// slow rates, in CLK_25MHZ cycles
////////////////////////////////////////

`define BIT_DIV      1000 // one LFSR step per period
`define SAMPLE_DIV   70   // one scope record per period

////////////////////////////////////////
// prbs generator
////////////////////////////////////////

`define LFSR_W       5
`define LFSR_SEED    1
// x^5 + x^3 + 1, feedback from these two state bits
`define LFSR_TAP_A   4
`define LFSR_TAP_B   2

`endif

// ==== include/sine_quarter_table.svh ====
`ifndef SINE_QUARTER_TABLE_SVH
`define SINE_QUARTER_TABLE_SVH

// first quadrant of the sine, full scale 2047
// entry a holds sin((2a+1) * pi / 256), i.e. sampled at half-step centres,
// so mirroring the address for quadrants 1 and 3 gives a symmetric wave
// with no repeated peak or zero sample

localparam logic [`SAMPLE_W-1:0] sine_quarter_lut [2**`TABLE_AW] = '{
   12'd25,   12'd75,   12'd126,  12'd176,   // 0..3
   12'd226,  12'd275,  12'd325,  12'd375,   // 4..7
   12'd424,  12'd473,  12'd522,  12'd570,   // 8..11
   12'd618,  12'd666,  12'd713,  12'd760,   // 12..15
   12'd807,  12'd852,  12'd898,  12'd943,   // 16..19
   12'd987,  12'd1031, 12'd1074, 12'd1116,  // 20..23
   12'd1158, 12'd1199, 12'd1239, 12'd1279,  // 24..27
   12'd1318, 12'd1356, 12'd1393, 12'd1430,  // 28..31
   12'd1465, 12'd1500, 12'd1533, 12'd1566,  // 32..35
   12'd1598, 12'd1629, 12'd1659, 12'd1688,  // 36..39
   12'd1716, 12'd1743, 12'd1769, 12'd1793,  // 40..43
   12'd1817, 12'd1840, 12'd1861, 12'd1881,  // 44..47
   12'd1901, 12'd1919, 12'd1936, 12'd1951,  // 48..51
   12'd1966, 12'd1979, 12'd1992, 12'd2003,  // 52..55
   12'd2012, 12'd2021, 12'd2028, 12'd2035,  // 56..59
   12'd2039, 12'd2043, 12'd2046, 12'd2047   // 60..63
};

// peak is 2047 so the negated lower half never reaches -2048
// and a BPSK flip of the cosine cannot overflow

`endif

// ==== design/dds_pkg.sv ====
package dds_pkg;

`include "dds_params.svh"
`include "sine_quarter_table.svh"

   ////////////////////////////////////////
   // scalar types
   ////////////////////////////////////////

   typedef logic signed [`SAMPLE_W-1:0] sample_t;
   typedef logic [`PHASE_W-1:0]         phase_t;
   typedef logic [`PHASE_IDX_W-1:0]     phase_idx_t;
   typedef logic [`LFSR_W-1:0]          lfsr_t;

   typedef enum logic [1:0] {WAVE_SIN, WAVE_COS, WAVE_SAW, WAVE_SQU} wave_sel_t;

   // KEY_OFF sits in the old FSK slot and gives zero
   typedef enum logic [1:0] {KEY_ASK, KEY_OFF, KEY_BPSK, KEY_RAW} key_sel_t;

   ////////////////////////////////////////
   // records
   ////////////////////////////////////////

   typedef struct packed {
      sample_t    sin;
      sample_t    cos;
      sample_t    saw;
      sample_t    squ;
      phase_idx_t phase_idx;   // index all four waves came from
   } carrier_set_t;

   typedef struct packed {
      sample_t    wave;        // selected carrier
      sample_t    keyed;       // modulated output
      phase_idx_t phase_idx;
      lfsr_t      lfsr;
   } scope_sample_t;

   // first-quadrant magnitude lookup
   function automatic logic [`SAMPLE_W-1:0] quarter_sine(input logic [`TABLE_AW-1:0] addr);
      return sine_quarter_lut[addr];
   endfunction

endpackage

// ==== design/carrier_dds.sv ====
`timescale 1ns/1ps
`include "dds_params.svh"

module carrier_dds (
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_pkg::phase_t       phase_inc,
   output dds_pkg::carrier_set_t carriers
);

   import dds_pkg::*;

   localparam sample_t    squ_hi       = sample_t'(2**(`SAMPLE_W-1) - 1);   // +2047
   localparam sample_t    squ_lo       = sample_t'(2**(`SAMPLE_W-1));       // -2048
   localparam phase_idx_t quarter_turn = phase_idx_t'(1) << (`PHASE_IDX_W-2);

   phase_t     phase;
   phase_idx_t idx;

   // full sine from the quarter table
   // quadrant from the two top index bits, address from the next six
   function automatic sample_t sine_at(input phase_idx_t i);
      logic [1:0]           quad;
      logic [`TABLE_AW-1:0] addr;
      sample_t              mag;
      quad = i[`PHASE_IDX_W-1 -: 2];
      addr = i[`PHASE_IDX_W-3 -: `TABLE_AW];
      if (quad[0])
      begin
         addr = ~addr;   // falling half of the hump
      end
      mag = sample_t'(quarter_sine(addr));
      return quad[1] ? -mag : mag;
   endfunction

   ////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + phase_inc;   // wraps mod 2^32
      end
   end

   assign idx = phase[`PHASE_W-1 -: `PHASE_IDX_W];

   ////////////////////////////////////////
   // waveform register, one cycle behind phase
   ////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      carriers.sin       <= sine_at(idx);
      carriers.cos       <= sine_at(idx + quarter_turn);   // 90 degrees ahead
      carriers.saw       <= sample_t'({~idx[`PHASE_IDX_W-1], idx[`PHASE_IDX_W-2:0]});
      carriers.squ       <= idx[`PHASE_IDX_W-1] ? squ_lo : squ_hi;
      carriers.phase_idx <= idx;   // tag travels with its waves
   end

   // square sits on the rail that matches the sign of the sine
   squ_on_rails: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      carriers.squ == ((carriers.sin > 0) ? squ_hi : squ_lo));

endmodule

// ==== design/prbs_bit_source.sv ====
`timescale 1ns/1ps
`include "dds_params.svh"

module prbs_bit_source (
   input  logic           CLK_25MHZ,
   input  logic           reset_from_key,
   output dds_pkg::lfsr_t lfsr
);

   import dds_pkg::*;

   localparam int cnt_w = $clog2(`BIT_DIV);

   logic [cnt_w-1:0] bit_cnt;
   logic             bit_tick;
   logic             feedback;

   ////////////////////////////////////////
   // bit-rate tick
   ////////////////////////////////////////

   assign bit_tick = (bit_cnt == cnt_w'(`BIT_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         bit_cnt <= '0;
      end
      else if (bit_tick)
      begin
         bit_cnt <= '0;
      end
      else
      begin
         bit_cnt <= bit_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // 5-bit maximal length shift register
   ////////////////////////////////////////

   assign feedback = lfsr[`LFSR_TAP_A] ^ lfsr[`LFSR_TAP_B];   // period 31

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr <= lfsr_t'(`LFSR_SEED);
      end
      else if (bit_tick)
      begin
         lfsr <= {lfsr[`LFSR_W-2:0], feedback};   // data bit shows up in bit 0
      end
   end

   // all-zero state would lock the generator up
   lfsr_not_stuck: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr != '0);

endmodule

// ==== design/keying_modulator.sv ====
`timescale 1ns/1ps
`include "dds_params.svh"

module keying_modulator (
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  dds_pkg::carrier_set_t  carriers,
   input  dds_pkg::lfsr_t         lfsr,
   input  dds_pkg::wave_sel_t     wave_sel,
   input  dds_pkg::key_sel_t      key_sel,
   output logic                   sample_valid,
   output dds_pkg::scope_sample_t scope
);

   import dds_pkg::*;

   localparam int cnt_w = $clog2(`SAMPLE_DIV);

   sample_t          wave;
   sample_t          keyed;
   sample_t          raw_level;
   logic             data_bit;
   logic [cnt_w-1:0] smp_cnt;
   logic             smp_tick;

   ////////////////////////////////////////
   // carrier select and keying
   ////////////////////////////////////////

   assign data_bit  = lfsr[0];
   // raw state parked in bits 10..6, sign bit clear
   assign raw_level = {1'b0, lfsr, {(`SAMPLE_W - 1 - `LFSR_W){1'b0}}};

   always_comb
   begin
      case (wave_sel)
         WAVE_SIN: wave = carriers.sin;
         WAVE_COS: wave = carriers.cos;
         WAVE_SAW: wave = carriers.saw;
         default:  wave = carriers.squ;
      endcase
   end

   always_comb
   begin
      case (key_sel)
         KEY_ASK:  keyed = data_bit ? carriers.cos : '0;              // on/off keying
         KEY_BPSK: keyed = data_bit ? carriers.cos : -carriers.cos;   // 180 degree flip
         KEY_RAW:  keyed = raw_level;
         default:  keyed = '0;                                        // old FSK slot
      endcase
   end

   ////////////////////////////////////////
   // decimation to scope rate
   ////////////////////////////////////////

   assign smp_tick = (smp_cnt == cnt_w'(`SAMPLE_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         smp_cnt      <= '0;
         sample_valid <= 1'b0;
      end
      else
      begin
         smp_cnt      <= smp_tick ? '0 : smp_cnt + 1'b1;
         sample_valid <= smp_tick;   // single-cycle strobe
      end
   end

   // all four fields from the same carrier set and lfsr state
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         scope <= '0;
      end
      else if (smp_tick)
      begin
         scope.wave      <= wave;
         scope.keyed     <= keyed;
         scope.phase_idx <= carriers.phase_idx;
         scope.lfsr      <= lfsr;
      end
   end

   // strobe never stretches, so no record is seen twice
   valid_is_pulse: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      sample_valid |=> !sample_valid);

endmodule

// ==== design/dds_keying_top.sv ====
`timescale 1ns/1ps

module dds_keying_top (
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  dds_pkg::phase_t        phase_inc,
   input  dds_pkg::wave_sel_t     wave_sel,
   input  dds_pkg::key_sel_t      key_sel,
   output logic                   sample_valid,
   output dds_pkg::scope_sample_t scope
);

   import dds_pkg::*;

   carrier_set_t carriers;   // level, valid every cycle
   lfsr_t        lfsr;       // level, steps on bit ticks

   ////////////////////////////////////////
   // carrier generation
   ////////////////////////////////////////

   carrier_dds u_carrier_dds (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .carriers       (carriers)
   );

   prbs_bit_source u_prbs_bit_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr           (lfsr)
   );

   ////////////////////////////////////////
   // keying and scope samples
   ////////////////////////////////////////

   keying_modulator u_keying_modulator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .carriers       (carriers),
      .lfsr           (lfsr),
      .wave_sel       (wave_sel),
      .key_sel        (key_sel),
      .sample_valid   (sample_valid),
      .scope          (scope)
   );

endmodule

// ==== tests/scope_checker.sv ====
`timescale 1ns/1ps
`include "dds_params.svh"

module scope_checker (
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  logic                   sample_valid,
   input  dds_pkg::scope_sample_t scope,
   input  dds_pkg::phase_t        phase_inc,
   input  dds_pkg::wave_sel_t     wave_sel,
   input  dds_pkg::key_sel_t      key_sel,
   input  int                     test_id,
   input  logic                   test_end,
   input  int                     expect_states,
   output int                     errors,
   output int                     checks
);

   import dds_pkg::*;

   localparam real pi = 3.14159265358979;

   int          error_count  = 0;
   int          check_count  = 0;
   int          test_errors  = 0;
   int          test_samples = 0;
   int          gap          = 0;   // cycles since last strobe or reset
   logic [31:0] states_seen  = '0;
   logic        have_lfsr    = 1'b0;
   logic        have_phase   = 1'b0;
   lfsr_t       last_lfsr;
   phase_idx_t  last_idx;
   phase_t      last_inc;

   assign errors = error_count;
   assign checks = check_count;

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   // magnitude taken at the half-step points of the quarter wave
   function automatic int ref_sine(input phase_idx_t i);
      int  a;
      real mag;
      a = int'(i[9:4]);
      if (i[10])
         a = 63 - a;   // mirrored quadrants
      mag = 2047.0 * $sin((2.0 * a + 1.0) * pi / 256.0);
      return i[11] ? -$rtoi(mag + 0.5) : $rtoi(mag + 0.5);
   endfunction

   function automatic int ref_wave(input phase_idx_t i, input wave_sel_t sel);
      case (sel)
         WAVE_SIN: return ref_sine(i);
         WAVE_COS: return ref_sine(i + 12'd1024);
         WAVE_SAW: return int'(i) - 2048;   // ramp from -2048 up to 2047
         default:  return (int'(i) < 2048) ? 2047 : -2048;   // high in first half turn
      endcase
   endfunction

   function automatic int ref_keyed(input phase_idx_t i, input lfsr_t s, input key_sel_t sel);
      int c;
      c = ref_sine(i + 12'd1024);
      case (sel)
         KEY_ASK:  return s[0] ? c : 0;
         KEY_BPSK: return s[0] ? c : -c;
         KEY_RAW:  return int'(s) << 6;   // state in bits 10..6
         default:  return 0;
      endcase
   endfunction

   // x^5 + x^3 + 1
   function automatic lfsr_t next_lfsr(input lfsr_t s);
      return {s[3:0], s[4] ^ s[2]};
   endfunction

   task automatic compare(input string what, input int got, input int exp, input int tol);
      check_count++;
      if (got - exp > tol || exp - got > tol)
      begin
         $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         error_count++;
         test_errors++;
      end
   endtask

   ////////////////////////////////////////
   // per-record checks
   ////////////////////////////////////////

   task automatic check_record();
      int tol;
      int ktol;
      tol  = (wave_sel == WAVE_SIN || wave_sel == WAVE_COS) ? 1 : 0;
      ktol = (key_sel == KEY_ASK || key_sel == KEY_BPSK) ? 1 : 0;   // only cosine rounds
      compare("sample spacing", gap, `SAMPLE_DIV, 0);
      compare("wave", int'(scope.wave), ref_wave(scope.phase_idx, wave_sel), tol);
      compare("keyed", int'(scope.keyed), ref_keyed(scope.phase_idx, scope.lfsr, key_sel), ktol);
      if (have_phase && phase_inc[19:0] == '0)
         compare("phase step", int'(scope.phase_idx),
                 (int'(last_idx) + int'(phase_inc[31:20]) * `SAMPLE_DIV) % 4096, 0);
      if (!have_lfsr)
         compare("first lfsr", int'(scope.lfsr), `LFSR_SEED, 0);
      else if (scope.lfsr != last_lfsr)
         compare("lfsr step", int'(scope.lfsr), int'(next_lfsr(last_lfsr)), 0);
      if (scope.lfsr == '0)
         compare("lfsr state", 0, 1, 0);   // all-zero lockup
      states_seen[scope.lfsr] = 1'b1;
      last_lfsr  = scope.lfsr;
      last_idx   = scope.phase_idx;
      have_lfsr  = 1'b1;
      have_phase = 1'b1;
      test_samples++;
   endtask

   task automatic finish_test();
      if (expect_states != 0)
         compare("distinct lfsr states", $countones(states_seen), expect_states, 0);
      $display("test %0d finished: %0d samples, %0d errors", test_id, test_samples, test_errors);
      test_samples = 0;
      test_errors  = 0;
      states_seen  = '0;
   endtask

   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         gap        = 0;
         have_lfsr  = 1'b0;
         have_phase = 1'b0;
         last_inc   = phase_inc;
      end
      else
      begin
         if (phase_inc != last_inc)
            have_phase = 1'b0;   // new rate, restart step tracking
         last_inc = phase_inc;
         if (sample_valid)
         begin
            check_record();
            gap = 1;
         end
         else
         begin
            gap++;
            if (!have_lfsr)
               compare("scope bits set before first sample", $countones(scope), 0, 0);
         end
         if (test_end)
            finish_test();
      end
   end

endmodule

// ==== tests/tb_dds_keying.sv ====
`timescale 1ns/1ps
`include "dds_params.svh"

module tb_dds_keying;

   import dds_pkg::*;

   localparam int n_rows = 8;

   typedef struct packed {
      phase_t      inc;
      wave_sel_t   wave;
      key_sel_t    key;
      logic [15:0] samples;   // strobes per row
      logic [5:0]  states;    // expected distinct lfsr states, zero skips
   } row_t;

   logic          CLK_25MHZ;
   logic          reset_from_key;
   phase_t        phase_inc;
   wave_sel_t     wave_sel;
   key_sel_t      key_sel;
   logic          sample_valid;
   scope_sample_t scope;

   int          test_id;
   logic        test_end;
   int          expect_states;
   int          errors;
   int          checks;
   row_t        rows [n_rows];
   int          limit;
   int          cycles;
   int          seen;
   int          total;
   int          r;

   dds_keying_top UUT (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .wave_sel       (wave_sel),
      .key_sel        (key_sel),
      .sample_valid   (sample_valid),
      .scope          (scope)
   );

   scope_checker u_scope_checker (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sample_valid   (sample_valid),
      .scope          (scope),
      .phase_inc      (phase_inc),
      .wave_sel       (wave_sel),
      .key_sel        (key_sel),
      .test_id        (test_id),
      .test_end       (test_end),
      .expect_states  (expect_states),
      .errors         (errors),
      .checks         (checks)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz
   end

   ////////////////////////////////////////
   // stimulus table and sequencing
   ////////////////////////////////////////

   initial
   begin
      reset_from_key = 1'b1;
      phase_inc      = '0;
      wave_sel       = WAVE_SIN;
      key_sel        = KEY_ASK;
      test_id        = 0;
      test_end       = 1'b0;
      expect_states  = 0;
      limit          = 0;
      void'($urandom(37));

      rows[0] = '{$urandom(), WAVE_SIN, KEY_ASK,  16'd12,  6'd0};
      rows[1] = '{$urandom(), WAVE_COS, KEY_BPSK, 16'd12,  6'd0};
      rows[2] = '{$urandom(), WAVE_SAW, KEY_OFF,  16'd10,  6'd0};
      rows[3] = '{$urandom(), WAVE_SQU, KEY_RAW,  16'd10,  6'd0};
      rows[4] = '{32'd37 << 20, WAVE_COS, KEY_BPSK, 16'd460, 6'd31};   // long row, full lfsr period
      rows[5] = '{$urandom(), WAVE_SIN, KEY_ASK,  16'd16,  6'd0};
      rows[6] = '{$urandom(), WAVE_SQU, KEY_OFF,  16'd10,  6'd0};
      rows[7] = '{$urandom(), WAVE_SAW, KEY_RAW,  16'd10,  6'd0};

      total = 0;
      for (r = 0; r < n_rows; r++)
         total += int'(rows[r].samples);
      limit = total * `SAMPLE_DIV * 3 / 2;

      repeat (4) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;

      for (r = 0; r < n_rows; r++)
      begin
         phase_inc     <= rows[r].inc;
         wave_sel      <= rows[r].wave;
         key_sel       <= rows[r].key;
         test_id       <= r;
         expect_states <= int'(rows[r].states);
         seen = 0;
         while (seen < int'(rows[r].samples))
         begin
            @(posedge CLK_25MHZ);
            if (sample_valid)
               seen++;
         end
         test_end <= 1'b1;   // checker closes the row on the next edge
         @(posedge CLK_25MHZ);
         test_end <= 1'b0;
      end

      @(negedge CLK_25MHZ);
      $display("summary: %0d tests, %0d checks, %0d errors", n_rows, checks, errors);
      if (errors == 0 && checks > 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   // watchdog
   initial
   begin
      cycles = 0;
      wait (limit != 0);
      while (cycles < limit)
      begin
         @(posedge CLK_25MHZ);
         cycles++;
      end
      $display("timeout: run did not finish within %0d clock cycles", limit);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+include
design/dds_pkg.sv
design/carrier_dds.sv
design/prbs_bit_source.sv
design/keying_modulator.sv
design/dds_keying_top.sv
tests/scope_checker.sv
tests/tb_dds_keying.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_dds_keying -o sim_dds_keying \
   && ./obj_dir/sim_dds_keying | tee /dev/stderr | grep -q "TEST OK" \
   && echo "simulation passed" && exit 0 \
   || { echo "simulation failed"; exit 1; }
